/* design/mem_map_pkg.sv */
`default_nettype none

package mem_map_pkg;

  ////////////////////////////////////////////////////////////
  // Bus widths of the native iomem interface
  ////////////////////////////////////////////////////////////

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int STRB_W = DATA_W / 8;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [STRB_W-1:0] strb_t;

  ////////////////////////////////////////////////////////////
  // Address map
  ////////////////////////////////////////////////////////////

  // Main RAM region, base plus offset mask
  localparam addr_t RAM_BASE      = 32'h4000_0000;
  localparam addr_t RAM_MASK      = 32'h000F_FFFF;

  // Cycle timer, two read-only words
  localparam addr_t TIMER_LO_ADDR = 32'h3000_0000;
  localparam addr_t TIMER_HI_ADDR = 32'h3000_0004;

  // Lowest address bit of the word index
  localparam int WORD_LSB = 2;

endpackage

`default_nettype wire

/* design/platform_pkg.sv */
`default_nettype none

package platform_pkg;

  // RAM geometry, kept small for simulation
  localparam int RAM_DEPTH = 1024;
  localparam int RAM_IDX_W = $clog2(RAM_DEPTH);
  typedef logic [RAM_IDX_W-1:0] ram_idx_t;

  // Emulated external memory latency
  localparam int RAM_DELAY = 16;
  localparam int DLY_CNT_W = $clog2(RAM_DELAY);
  typedef logic [DLY_CNT_W-1:0] dly_cnt_t;

  // Free-running cycle count
  typedef logic [63:0] timer_t;

  // UART bit timing, oversampled
  localparam int CLKS_PER_BIT = 16;
  localparam int BAUD_CNT_W = $clog2(CLKS_PER_BIT);
  typedef logic [BAUD_CNT_W-1:0] baud_cnt_t;
  typedef logic [7:0] byte_t;
  typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

  // Loader protocol, magic byte then 16-bit word count
  localparam byte_t LOAD_MAGIC = 8'hA5;
  typedef logic [15:0] word_cnt_t;
  typedef enum logic [2:0] {
    LD_IDLE, LD_COUNT_LO, LD_COUNT_HI, LD_DATA, LD_DONE
  } loader_state_e;

endpackage

`default_nettype wire

/* design/ram_port_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface ram_port_if;
  import mem_map_pkg::*;
  import platform_pkg::*;

  // One-cycle access strobe
  logic     en;
  // Nonzero means write, zero means read
  strb_t    wstrb;
  ram_idx_t idx;
  data_t    wdata;
  // Read data, valid the cycle after a read and held
  data_t    rdata;

  // Side that issues accesses
  modport requester (
    output en,
    output wstrb,
    output idx,
    output wdata,
    input  rdata
  );

  // Side that holds the array
  modport memory (
    input  en,
    input  wstrb,
    input  idx,
    input  wdata,
    output rdata
  );

endinterface

`default_nettype wire

/* design/iomem_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

module iomem_decoder (
  input  logic               clk_i,
  input  logic               rst_n,
  input  logic               host_valid_i,
  input  mem_map_pkg::strb_t host_wstrb_i,
  input  mem_map_pkg::addr_t host_addr_i,
  input  mem_map_pkg::data_t host_wdata_i,
  output logic               host_ready_o,
  output mem_map_pkg::data_t host_rdata_o,
  ram_port_if.requester      ram
);
  import mem_map_pkg::*;
  import platform_pkg::*;

  logic     ram_sel;
  logic     tlo_sel;
  logic     thi_sel;
  logic     timer_sel;
  logic     unmapped_sel;
  logic     ram_start;
  logic     ram_busy_q;
  dly_cnt_t ram_cnt_q;
  logic     ram_done;
  logic     unm_ready_q;
  timer_t   timer_q;

  ////////////////////////////////////////////////////////////
  // Region decode
  ////////////////////////////////////////////////////////////

  assign ram_sel      = ((host_addr_i & ~RAM_MASK) == RAM_BASE);
  assign tlo_sel      = (host_addr_i == TIMER_LO_ADDR);
  assign thi_sel      = (host_addr_i == TIMER_HI_ADDR);
  assign timer_sel    = tlo_sel | thi_sel;
  assign unmapped_sel = ~ram_sel & ~timer_sel;

  ////////////////////////////////////////////////////////////
  // RAM wait emulation
  ////////////////////////////////////////////////////////////

  // First cycle of a RAM request, busy blocks a second issue
  assign ram_start = host_valid_i & ram_sel & ~ram_busy_q;

  // Down-counter loaded on issue, ready when it reaches zero
  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      ram_busy_q <= 1'b0;
      ram_cnt_q  <= '0;
    end else if (ram_start) begin
      ram_busy_q <= 1'b1;
      ram_cnt_q  <= dly_cnt_t'(RAM_DELAY - 1);
    end else if (ram_busy_q) begin
      if (ram_cnt_q == '0) begin
        ram_busy_q <= 1'b0;
      end else begin
        ram_cnt_q <= ram_cnt_q - 1'b1;
      end
    end
  end

  assign ram_done = ram_busy_q & (ram_cnt_q == '0);

  // Single access on the first cycle only
  assign ram.en    = ram_start;
  assign ram.wstrb = host_wstrb_i;
  assign ram.idx   = host_addr_i[WORD_LSB +: RAM_IDX_W];
  assign ram.wdata = host_wdata_i;

  // Unmapped space acks one cycle late so the bus never hangs
  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      unm_ready_q <= 1'b0;
    end else begin
      unm_ready_q <= host_valid_i & unmapped_sel & ~unm_ready_q;
    end
  end

  ////////////////////////////////////////////////////////////
  // Cycle timer
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      timer_q <= '0;
    end else begin
      timer_q <= timer_q + 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // Ready and read data mux
  ////////////////////////////////////////////////////////////

  // Timer words answer in the same cycle
  assign host_ready_o = (host_valid_i & timer_sel) | ram_done | unm_ready_q;

  always_comb begin
    if (tlo_sel) begin
      host_rdata_o = timer_q[31:0];
    end else if (thi_sel) begin
      host_rdata_o = timer_q[63:32];
    end else if (ram_sel) begin
      host_rdata_o = ram.rdata;
    end else begin
      // Unmapped reads return zero
      host_rdata_o = '0;
    end
  end

endmodule

`default_nettype wire

/* design/main_ram.sv */
`timescale 1ns/10ps
`default_nettype none

module main_ram (
  input logic        clk_i,
  ram_port_if.memory host,
  ram_port_if.memory load
);
  import mem_map_pkg::*;
  import platform_pkg::*;

  data_t    mem_q [RAM_DEPTH];
  logic     load_wr;
  logic     host_wr;
  logic     host_rd;
  logic     wr_en;
  strb_t    wr_strb;
  ram_idx_t wr_idx;
  data_t    wr_data;
  data_t    rdata_q;

  // Loader write takes the cycle, host access is dropped
  assign load_wr = load.en & (|load.wstrb);
  assign host_wr = host.en & (|host.wstrb) & ~load_wr;
  assign host_rd = host.en & ~(|host.wstrb) & ~load_wr;

  // Shared write port select
  always_comb begin
    wr_en = load_wr | host_wr;
    if (load_wr) begin
      wr_strb = load.wstrb;
      wr_idx  = load.idx;
      wr_data = load.wdata;
    end else begin
      wr_strb = host.wstrb;
      wr_idx  = host.idx;
      wr_data = host.wdata;
    end
  end

  // Byte lane writes
  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (wr_strb[b]) begin
          mem_q[wr_idx][8*b +: 8] <= wr_data[8*b +: 8];
        end
      end
    end
  end

  // Registered read, held until the next read
  always_ff @(posedge clk_i) begin
    if (host_rd) begin
      rdata_q <= mem_q[host.idx];
    end
  end

  assign host.rdata = rdata_q;
  // Loader side is write only
  assign load.rdata = '0;

endmodule

`default_nettype wire

/* design/prog_loader.sv */
`timescale 1ns/10ps
`default_nettype none

module prog_loader (
  input  logic          clk_i,
  input  logic          rst_n,
  input  logic          prog_rx_i,
  output logic          prog_mode_o,
  output logic          sys_rst_n_o,
  ram_port_if.requester wr
);
  import mem_map_pkg::*;
  import platform_pkg::*;

  logic          rx_meta_q;
  logic          rx_sync_q;
  rx_state_e     rx_state_q;
  baud_cnt_t     baud_cnt_q;
  logic [2:0]    bit_idx_q;
  byte_t         rx_shift_q;
  logic          rx_valid_q;
  logic          baud_mid;
  logic          baud_end;
  loader_state_e ld_state_q;
  word_cnt_t     word_total_q;
  word_cnt_t     word_num_q;
  logic [1:0]    byte_num_q;
  data_t         word_q;
  logic          wr_en_q;
  logic          prog_mode_q;
  logic          last_word;

  ////////////////////////////////////////////////////////////
  // UART receiver
  ////////////////////////////////////////////////////////////

  // Two-flop synchronizer, idle line is high
  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      rx_meta_q <= 1'b1;
      rx_sync_q <= 1'b1;
    end else begin
      rx_meta_q <= prog_rx_i;
      rx_sync_q <= rx_meta_q;
    end
  end

  assign baud_mid = (baud_cnt_q == baud_cnt_t'(CLKS_PER_BIT / 2 - 1));
  assign baud_end = (baud_cnt_q == baud_cnt_t'(CLKS_PER_BIT - 1));

  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      rx_state_q <= RX_IDLE;
      baud_cnt_q <= '0;
      bit_idx_q  <= '0;
      rx_valid_q <= 1'b0;
    end else begin
      rx_valid_q <= 1'b0;
      baud_cnt_q <= baud_cnt_q + 1'b1;
      case (rx_state_q)
        RX_IDLE: begin
          baud_cnt_q <= '0;
          if (!rx_sync_q) begin
            rx_state_q <= RX_START;
          end
        end
        // Recheck start at mid-bit, a glitch goes back to idle
        RX_START: begin
          if (baud_mid) begin
            baud_cnt_q <= '0;
            bit_idx_q  <= '0;
            rx_state_q <= rx_sync_q ? RX_IDLE : RX_DATA;
          end
        end
        RX_DATA: begin
          if (baud_end) begin
            baud_cnt_q <= '0;
            bit_idx_q  <= bit_idx_q + 1'b1;
            if (bit_idx_q == 3'd7) begin
              rx_state_q <= RX_STOP;
            end
          end
        end
        // Byte counts only with a good stop bit
        RX_STOP: begin
          if (baud_end) begin
            rx_valid_q <= rx_sync_q;
            rx_state_q <= RX_IDLE;
          end
        end
        default: rx_state_q <= RX_IDLE;
      endcase
    end
  end

  // LSB first into the top of the shifter
  always_ff @(posedge clk_i) begin
    if (rx_state_q == RX_DATA && baud_end) begin
      rx_shift_q <= {rx_sync_q, rx_shift_q[7:1]};
    end
  end

  ////////////////////////////////////////////////////////////
  // Programming FSM
  ////////////////////////////////////////////////////////////

  assign last_word = (word_num_q == word_total_q - 1'b1);

  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      ld_state_q  <= LD_IDLE;
      prog_mode_q <= 1'b0;
      wr_en_q     <= 1'b0;
      word_num_q  <= '0;
      byte_num_q  <= '0;
    end else begin
      wr_en_q <= 1'b0;
      // Index moves on after each write
      if (wr_en_q) begin
        word_num_q <= word_num_q + 1'b1;
      end
      case (ld_state_q)
        LD_IDLE: begin
          if (rx_valid_q && rx_shift_q == LOAD_MAGIC) begin
            prog_mode_q <= 1'b1;
            word_num_q  <= '0;
            byte_num_q  <= '0;
            ld_state_q  <= LD_COUNT_LO;
          end
        end
        LD_COUNT_LO: begin
          if (rx_valid_q) begin
            ld_state_q <= LD_COUNT_HI;
          end
        end
        // Empty image ends at once
        LD_COUNT_HI: begin
          if (rx_valid_q) begin
            ld_state_q <= ({rx_shift_q, word_total_q[7:0]} == '0) ? LD_DONE : LD_DATA;
          end
        end
        LD_DATA: begin
          if (rx_valid_q) begin
            byte_num_q <= byte_num_q + 1'b1;
            if (byte_num_q == 2'd3) begin
              wr_en_q <= 1'b1;
              if (last_word) begin
                ld_state_q <= LD_DONE;
              end
            end
          end
        end
        // Last write is on the bus this cycle
        LD_DONE: begin
          prog_mode_q <= 1'b0;
          ld_state_q  <= LD_IDLE;
        end
        default: ld_state_q <= LD_IDLE;
      endcase
    end
  end

  // Count and little-endian word assembly
  always_ff @(posedge clk_i) begin
    if (rx_valid_q) begin
      if (ld_state_q == LD_COUNT_LO) begin
        word_total_q[7:0] <= rx_shift_q;
      end
      if (ld_state_q == LD_COUNT_HI) begin
        word_total_q[15:8] <= rx_shift_q;
      end
      if (ld_state_q == LD_DATA) begin
        word_q <= {rx_shift_q, word_q[31:8]};
      end
    end
  end

  // Full-word writes at sequential indices
  assign wr.en    = wr_en_q;
  assign wr.wstrb = '1;
  assign wr.idx   = word_num_q[RAM_IDX_W-1:0];
  assign wr.wdata = word_q;

  assign prog_mode_o = prog_mode_q;
  // System held in reset while loading
  assign sys_rst_n_o = rst_n & ~prog_mode_q;

endmodule

`default_nettype wire

/* design/soc_mem_top.sv */
`timescale 1ns/10ps
`default_nettype none

module soc_mem_top (
  input  logic               clk_i,
  input  logic               rst_n,
  input  logic               prog_rx_i,
  input  logic               host_valid_i,
  input  mem_map_pkg::strb_t host_wstrb_i,
  input  mem_map_pkg::addr_t host_addr_i,
  input  mem_map_pkg::data_t host_wdata_i,
  output logic               host_ready_o,
  output mem_map_pkg::data_t host_rdata_o,
  output logic               prog_mode_o,
  output logic               sys_rst_n_o
);

  // Host side and loader side of the RAM
  ram_port_if host_port ();
  ram_port_if load_port ();

  // Loader runs on the board reset
  prog_loader u_loader (
    .clk_i       (clk_i),
    .rst_n       (rst_n),
    .prog_rx_i   (prog_rx_i),
    .prog_mode_o (prog_mode_o),
    .sys_rst_n_o (sys_rst_n_o),
    .wr          (load_port)
  );

  // Decoder and timer follow the gated system reset
  iomem_decoder u_decoder (
    .clk_i        (clk_i),
    .rst_n        (sys_rst_n_o),
    .host_valid_i (host_valid_i),
    .host_wstrb_i (host_wstrb_i),
    .host_addr_i  (host_addr_i),
    .host_wdata_i (host_wdata_i),
    .host_ready_o (host_ready_o),
    .host_rdata_o (host_rdata_o),
    .ram          (host_port)
  );

  main_ram u_ram (
    .clk_i (clk_i),
    .host  (host_port),
    .load  (load_port)
  );

endmodule

`default_nettype wire

/* verif/soc_mem_sva.sv */
`timescale 1ns/10ps
`default_nettype none

module soc_mem_sva (
  input logic                   clk_i,
  input logic                   rst_n,
  input logic                   host_valid_i,
  input logic                   host_ready_i,
  input mem_map_pkg::addr_t     host_addr_i,
  input logic                   ram_start_i,
  input logic                   ram_busy_i,
  input logic                   unm_ready_i,
  input platform_pkg::timer_t   timer_i
);
  import platform_pkg::*;

  ////////////////////////////////////////////////////////////
  // Reset behaviour
  ////////////////////////////////////////////////////////////

  // Wait state, unmapped ack and timer all cleared
  reset_clears_a: assert property (@(posedge clk_i)
    !rst_n |=> !ram_busy_i && !unm_ready_i && (timer_i == '0))
    else $error("decoder state not cleared by reset");

  ////////////////////////////////////////////////////////////
  // Bus protocol
  ////////////////////////////////////////////////////////////

  // Fixed RAM wait from the single issue cycle
  ram_latency_a: assert property (@(posedge clk_i) disable iff (!rst_n)
    ram_start_i |-> ##RAM_DELAY host_ready_i)
    else $error("RAM ready not seen RAM_DELAY cycles after issue");

  ready_needs_valid_a: assert property (@(posedge clk_i) disable iff (!rst_n)
    host_ready_i |-> host_valid_i)
    else $error("ready without a pending request");

  // Host holds its request until ready
  req_stable_a: assert property (@(posedge clk_i) disable iff (!rst_n)
    host_valid_i && !host_ready_i |=> host_valid_i && $stable(host_addr_i))
    else $error("request dropped or changed before ready");

endmodule

bind iomem_decoder soc_mem_sva u_sva (
  .clk_i          (clk_i),
  .rst_n          (rst_n),
  .host_valid_i   (host_valid_i),
  .host_ready_i   (host_ready_o),
  .host_addr_i    (host_addr_i),
  .ram_start_i    (ram_start),
  .ram_busy_i     (ram_busy_q),
  .unm_ready_i    (unm_ready_q),
  .timer_i        (timer_q)
);

`default_nettype wire

/* verif/tb_checker.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_checker (
  input  logic               clk_i,
  input  logic               rst_n,
  input  logic               host_valid_i,
  input  mem_map_pkg::addr_t host_addr_i,
  input  logic               host_ready_i,
  input  mem_map_pkg::data_t host_rdata_i,
  input  logic               prog_mode_i,
  input  logic               sys_rst_n_i,
  input  logic               done_i,
  output int                 value_errs_o,
  output int                 other_errs_o,
  output int                 checked_o
);
  import mem_map_pkg::*;
  import platform_pkg::*;

  localparam string GOLDEN_FILE  = "verif/golden_vectors.txt";
  localparam int    GOLDEN_WORDS = 256;
  localparam int    REC_WORDS    = 5;

  logic [31:0] golden_q [GOLDEN_WORDS];
  int          n_ops;
  int          op_base;
  int          op_idx;
  int          wait_cnt;
  logic        in_req;
  logic        mode_seen;
  logic        done_seen;
  timer_t      timer_model;
  timer_t      cycle_cnt;
  logic        tlo_seen;
  data_t       tlo_data;
  timer_t      tlo_cycle;

  // Op records follow the byte stream in the golden file
  initial begin
    $readmemh(GOLDEN_FILE, golden_q);
    op_base      = golden_q[0] + 2;
    n_ops        = golden_q[op_base - 1];
    op_idx       = 0;
    wait_cnt     = 0;
    in_req       = 1'b0;
    mode_seen    = 1'b0;
    done_seen    = 1'b0;
    timer_model  = '0;
    cycle_cnt    = '0;
    tlo_seen     = 1'b0;
    value_errs_o = 0;
    other_errs_o = 0;
    checked_o    = 0;
  end

  // Latency by region of the address map
  function automatic int expected_latency(input addr_t a);
    if (a >= RAM_BASE && a <= (RAM_BASE | RAM_MASK)) begin
      return RAM_DELAY;
    end
    if (a == TIMER_LO_ADDR || a == TIMER_HI_ADDR) begin
      return 0;
    end
    return 1;
  endfunction

  task automatic check_value(input string name, input data_t exp, input data_t act);
    if (act !== exp) begin
      $display("FAIL %s: expected 0x%h, actual 0x%h", name, exp, act);
      value_errs_o++;
    end
  endtask

  task automatic flag_error(input string what);
    $display("ERROR: %s", what);
    other_errs_o++;
  endtask

  ////////////////////////////////////////////////////////////
  // Completed bus operation
  ////////////////////////////////////////////////////////////

  task automatic finish_op();
    int    rec;
    addr_t a;
    string name;
    rec = op_base + REC_WORDS * op_idx;
    a   = host_addr_i;
    if (golden_q[rec] != 0) begin
      name = $sformatf("op %0d write %h", op_idx, a);
    end else begin
      name = $sformatf("op %0d read %h", op_idx, a);
    end
    if (a !== golden_q[rec + 1]) begin
      flag_error($sformatf("%s does not match the address in the golden file", name));
    end
    check_value({name, " latency"}, data_t'(expected_latency(a)), data_t'(wait_cnt));
    if (golden_q[rec] == 0) begin
      if (a == TIMER_LO_ADDR) begin
        check_value({name, " timer count"}, timer_model[31:0], host_rdata_i);
        // Count difference equals cycles between the two ready cycles
        if (tlo_seen) begin
          check_value({name, " timer delta"}, data_t'(cycle_cnt - tlo_cycle),
                      host_rdata_i - tlo_data);
        end
        tlo_seen  = 1'b1;
        tlo_data  = host_rdata_i;
        tlo_cycle = cycle_cnt;
      end else if (a == TIMER_HI_ADDR) begin
        check_value(name, timer_model[63:32], host_rdata_i);
      end else begin
        check_value(name, golden_q[rec + 4], host_rdata_i);
      end
    end
    op_idx++;
    checked_o++;
  endtask

  ////////////////////////////////////////////////////////////
  // Per-cycle monitor
  ////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin
    if (!rst_n && (host_ready_i || prog_mode_i)) begin
      flag_error("ready or program mode high while reset is asserted");
    end
    if (prog_mode_i) begin
      mode_seen = 1'b1;
      if (sys_rst_n_i) begin
        flag_error("system reset released while in program mode");
      end
    end
    // Wait count from the first valid cycle of a request
    if (host_valid_i) begin
      if (!in_req) begin
        in_req   = 1'b1;
        wait_cnt = 0;
      end
      if (host_ready_i) begin
        if (op_idx < n_ops) begin
          finish_op();
        end else begin
          flag_error("bus operation beyond the end of the golden file");
        end
        in_req = 1'b0;
      end else begin
        wait_cnt++;
      end
    end else if (in_req) begin
      flag_error("valid dropped before ready");
      in_req = 1'b0;
    end
    if (done_i && !done_seen) begin
      done_seen = 1'b1;
      if (op_idx != n_ops) begin
        flag_error($sformatf("only %0d of %0d bus operations completed", op_idx, n_ops));
      end
      if (!mode_seen) begin
        flag_error("program mode never went high during loading");
      end
    end
    // Timer model held at zero while the system is in reset
    timer_model = sys_rst_n_i ? timer_model + 1'b1 : '0;
    cycle_cnt   = cycle_cnt + 1'b1;
  end

endmodule

`default_nettype wire

/* verif/tb_soc_mem.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_soc_mem;
  import mem_map_pkg::*;
  import platform_pkg::*;

  localparam string       GOLDEN_FILE  = "verif/golden_vectors.txt";
  localparam int          GOLDEN_WORDS = 256;
  localparam int          REC_WORDS    = 5;
  localparam int          CLK_HALF     = 20;
  localparam int          DRIVE_DLY    = 2;
  localparam int          RST_CYCLES   = 10;
  localparam int          GAP_BITS     = 4;
  localparam int          MAX_GAP      = (1 << GAP_BITS) - 1;
  localparam int          MARGIN       = 500;
  localparam logic [15:0] LFSR_SEED    = 16'd43;
  localparam logic [15:0] LFSR_TAPS    = 16'hB400;

  logic        clk_i;
  logic        rst_n;
  logic        prog_rx_i;
  logic        host_valid_i;
  strb_t       host_wstrb_i;
  addr_t       host_addr_i;
  data_t       host_wdata_i;
  logic        host_ready_o;
  data_t       host_rdata_o;
  logic        prog_mode_o;
  logic        sys_rst_n_o;
  logic        run_done;
  int          value_errs;
  int          other_errs;
  int          checked_ops;
  logic [31:0] golden_q [GOLDEN_WORDS];
  int          n_bytes;
  int          n_ops;
  int          op_base;
  int          cycle_cnt;
  int          cycle_limit = 1000000;
  logic [15:0] lfsr_q;

  soc_mem_top uut (
    .clk_i        (clk_i),
    .rst_n        (rst_n),
    .prog_rx_i    (prog_rx_i),
    .host_valid_i (host_valid_i),
    .host_wstrb_i (host_wstrb_i),
    .host_addr_i  (host_addr_i),
    .host_wdata_i (host_wdata_i),
    .host_ready_o (host_ready_o),
    .host_rdata_o (host_rdata_o),
    .prog_mode_o  (prog_mode_o),
    .sys_rst_n_o  (sys_rst_n_o)
  );

  tb_checker u_chk (
    .clk_i        (clk_i),
    .rst_n        (rst_n),
    .host_valid_i (host_valid_i),
    .host_addr_i  (host_addr_i),
    .host_ready_i (host_ready_o),
    .host_rdata_i (host_rdata_o),
    .prog_mode_i  (prog_mode_o),
    .sys_rst_n_i  (sys_rst_n_o),
    .done_i       (run_done),
    .value_errs_o (value_errs),
    .other_errs_o (other_errs),
    .checked_o    (checked_ops)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_HALF) clk_i = ~clk_i;
  end

  // Hard stop on cycle count
  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < cycle_limit) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("Timeout: run did not finish within %0d cycles", cycle_limit);
    $display("TESTS FAILED");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////

  // Galois form, right shift
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    if (s[0]) begin
      return (s >> 1) ^ LFSR_TAPS;
    end
    return s >> 1;
  endfunction

  // One LFSR step per bit taken
  task automatic take_bits(input int n, output int v);
    v = 0;
    for (int i = 0; i < n; i++) begin
      v = (v << 1) | int'(lfsr_q[0]);
      lfsr_q = lfsr_next(lfsr_q);
    end
  endtask

  // Line level for a whole number of clocks
  task automatic hold_line(input logic v, input int cycles);
    @(posedge clk_i);
    #DRIVE_DLY;
    prog_rx_i = v;
    repeat (cycles - 1) @(posedge clk_i);
  endtask

  // 8N1, LSB first, random idle gap ahead
  task automatic send_byte(input logic [7:0] b);
    int gap;
    take_bits(GAP_BITS, gap);
    if (gap > 0) begin
      hold_line(1'b1, gap);
    end
    hold_line(1'b0, CLKS_PER_BIT);
    for (int i = 0; i < 8; i++) begin
      hold_line(b[i], CLKS_PER_BIT);
    end
    hold_line(1'b1, CLKS_PER_BIT);
  endtask

  // Request held until ready on a rising edge
  task automatic bus_op(input int rec);
    @(posedge clk_i);
    #DRIVE_DLY;
    host_valid_i = 1'b1;
    host_addr_i  = golden_q[rec + 1];
    host_wdata_i = golden_q[rec + 2];
    host_wstrb_i = (golden_q[rec] != 0) ? golden_q[rec + 3][STRB_W-1:0] : '0;
    do begin
      @(posedge clk_i);
    end while (!host_ready_o);
    #DRIVE_DLY;
    host_valid_i = 1'b0;
    host_wstrb_i = '0;
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    prog_rx_i    = 1'b1;
    host_valid_i = 1'b0;
    host_wstrb_i = '0;
    host_addr_i  = '0;
    host_wdata_i = '0;
    rst_n        = 1'b0;
    run_done     = 1'b0;
    lfsr_q       = LFSR_SEED;
    $readmemh(GOLDEN_FILE, golden_q);
    n_bytes = golden_q[0];
    n_ops   = golden_q[n_bytes + 1];
    op_base = n_bytes + 2;
    // Serial bytes with worst gap, then bus ops at full RAM wait
    cycle_limit = RST_CYCLES + n_bytes * (10 * CLKS_PER_BIT + MAX_GAP)
                  + n_ops * (RAM_DELAY + 4) + MARGIN;
    repeat (RST_CYCLES) @(posedge clk_i);
    #DRIVE_DLY;
    rst_n = 1'b1;
    repeat (4) @(posedge clk_i);
    for (int i = 0; i < n_bytes; i++) begin
      send_byte(golden_q[1 + i][7:0]);
    end
    // Loader lets go of the system reset after the last word
    while (prog_mode_o || !sys_rst_n_o) begin
      @(posedge clk_i);
    end
    repeat (2) @(posedge clk_i);
    for (int k = 0; k < n_ops; k++) begin
      bus_op(op_base + REC_WORDS * k);
    end
    repeat (3) @(posedge clk_i);
    #DRIVE_DLY;
    run_done = 1'b1;
    repeat (2) @(posedge clk_i);
    $display("Summary: %0d value errors, %0d other errors, %0d of %0d operations checked",
             value_errs, other_errs, checked_ops, n_ops);
    if (value_errs == 0 && other_errs == 0 && checked_ops == n_ops) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* flist.f */
design/mem_map_pkg.sv
design/platform_pkg.sv
design/ram_port_if.sv
design/iomem_decoder.sv
design/main_ram.sv
design/prog_loader.sv
design/soc_mem_top.sv
verif/soc_mem_sva.sv
verif/tb_checker.sv
verif/tb_soc_mem.sv

/* Makefile */
# Verilator build and run for the memory-side platform testbench

VERILATOR ?= verilator
TOP       ?= tb_soc_mem
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= TESTS PASSED

BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# Output is echoed, pass is decided by an exact match on the pass line
run: compile
	@out="$$($(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* verif/golden_vectors.txt */
// Serial stream: byte count, then bytes (magic, count lo, count hi, image words LE)
// Bus ops: op count, then per line op (0 read, 1 write), addr, wdata, wstrb, expected
13
A5 04 00
78 56 34 12
EF BE AD DE
01 02 03 04
55 AA 0F F0
15
0 40000000 00000000 0 12345678
0 40000004 00000000 0 DEADBEEF
0 40000008 00000000 0 04030201
0 4000000C 00000000 0 F00FAA55
1 40000004 11223344 3 00000000
0 40000004 00000000 0 DEAD3344
1 40000008 AABBCCDD C 00000000
0 40000008 00000000 0 AABB0201
1 4000000C 00990000 4 00000000
0 4000000C 00000000 0 F099AA55
1 40000010 CAFEF00D F 00000000
0 40000010 00000000 0 CAFEF00D
// Timer words, expected column unused
0 30000000 00000000 0 00000000
0 40000000 00000000 0 12345678
0 30000000 00000000 0 00000000
1 30000000 FFFFFFFF F 00000000
0 30000000 00000000 0 00000000
0 30000004 00000000 0 00000000
// Unmapped space
0 20000000 00000000 0 00000000
1 20000000 12345678 F 00000000
0 40100000 00000000 0 00000000
